/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Opcodes are six bits wide throughout the core
	typedef logic [5:0] opcode_t;

	// Both load forms return data in the memory stage
	localparam opcode_t OP_LD  = 6'b010001;
	localparam opcode_t OP_LD2 = 6'b110000;

	// Store data comes from rs2
	localparam opcode_t OP_ST  = 6'b010000;
	localparam opcode_t OP_ST2 = 6'b010011;
	localparam opcode_t OP_ST3 = 6'b111000;

	// Jump target comes from rs1
	localparam opcode_t OP_JMP  = 6'b000101;
	localparam opcode_t OP_JMP2 = 6'b000111;

	function automatic logic is_load(input opcode_t op);
		return (op == OP_LD) || (op == OP_LD2);
	endfunction

	function automatic logic is_store(input opcode_t op);
		return (op == OP_ST) || (op == OP_ST2) || (op == OP_ST3);
	endfunction

	function automatic logic is_jump(input opcode_t op);
		return (op == OP_JMP) || (op == OP_JMP2);
	endfunction

endpackage

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int WORD_W = 32;

	typedef logic [4:0] reg_idx_t;
	typedef logic [WORD_W-1:0] word_t;

	// Loads return their address mixed with this value
	localparam word_t LOAD_SALT = 32'hc3a5_5a3c;

	// Decoded instruction as presented by the source
	typedef struct packed {
		isa_pkg::opcode_t opcode;
		reg_idx_t         rs1;
		reg_idx_t         rs2;
		reg_idx_t         rd;
		logic             rd_en;
		logic             reg2used;
		word_t            imm;
	} instr_t;

	// Execute stage payload
	typedef struct packed {
		logic             valid;
		isa_pkg::opcode_t opcode;
		reg_idx_t         rd;
		logic             rd_en;
		logic             reg2used;
		word_t            imm;
		word_t            rs1_val;
		word_t            rs2_val;
	} id_ex_t;

	// Memory stage payload
	typedef struct packed {
		logic             valid;
		isa_pkg::opcode_t opcode;
		reg_idx_t         rd;
		logic             rd_en;
		word_t            result;
		word_t            addr;
	} ex_mem_t;

	// Writeback stage payload
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     rd_en;
		word_t    result;
	} mem_wb_t;

endpackage

`default_nettype wire

/* logic/stage_reg.sv */
`default_nettype none
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// Hold wins over bubble so a frozen pipeline keeps its contents
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= payload_t'('0);
		end else if (!hold) begin
			if (bubble) begin
				q <= payload_t'('0);
			end else begin
				q <= d;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none
`timescale 1ns/1ns

module reg_file
	import core_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  reg_idx_t          rs1,
	input  reg_idx_t          rs2,
	input  logic              we,
	input  reg_idx_t          wd_idx,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rd1,
	output logic [DATA_W-1:0] rd2
);

	localparam int NUM_REGS = 32;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wd_idx] <= wdata;
		end
	end

	// Write-through so decode sees a value retiring in the same cycle
	assign rd1 = (we && (wd_idx == rs1)) ? wdata : regs[rs1];
	assign rd2 = (we && (wd_idx == rs2)) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`default_nettype none
`timescale 1ns/1ns

module operand_forward #(
	parameter int DATA_W = 32
) (
	input  logic [DATA_W-1:0] id_a,
	input  logic [DATA_W-1:0] id_b,
	input  logic [DATA_W-1:0] mem_result,
	input  logic [DATA_W-1:0] wb_result,
	input  logic              fwd_mem_a,
	input  logic              fwd_mem_b,
	input  logic              fwd_wb_a,
	input  logic              fwd_wb_b,
	output logic [DATA_W-1:0] op_a,
	output logic [DATA_W-1:0] op_b
);

	// The memory stage holds the younger producer, so it takes priority
	function automatic logic [DATA_W-1:0] pick(
		input logic              use_mem,
		input logic              use_wb,
		input logic [DATA_W-1:0] from_mem,
		input logic [DATA_W-1:0] from_wb,
		input logic [DATA_W-1:0] from_id
	);
		if (use_mem) begin
			return from_mem;
		end else if (use_wb) begin
			return from_wb;
		end
		return from_id;
	endfunction

	assign op_a = pick(fwd_mem_a, fwd_wb_a, mem_result, wb_result, id_a);
	assign op_b = pick(fwd_mem_b, fwd_wb_b, mem_result, wb_result, id_b);

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module exec_unit
	import core_pkg::*;
	import isa_pkg::*;
#(
	parameter int DATA_W = 32
) (
	// Execute stage
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] op_b,
	input  logic [DATA_W-1:0] imm,
	input  logic              reg2used,

	// Memory stage
	input  opcode_t           mem_opcode,
	input  logic [DATA_W-1:0] mem_result,
	input  logic [DATA_W-1:0] mem_addr,

	output logic [DATA_W-1:0] ex_result,
	output logic [DATA_W-1:0] ex_addr,
	output logic [DATA_W-1:0] load_result
);

	// Second operand is either rs2 or the immediate
	assign ex_result = reg2used ? (op_a + op_b) : (op_a + imm);
	assign ex_addr   = op_a + imm;

	// Stand-in for a data memory read
	assign load_result = is_load(mem_opcode) ? (mem_addr ^ DATA_W'(LOAD_SALT)) : mem_result;

endmodule

`default_nettype wire

/* logic/hazard_detect.sv */
`default_nettype none
`timescale 1ns/1ns

module hazard_detect
	import core_pkg::*;
	import isa_pkg::*;
(
	input  logic     clk,
	input  logic     reset,

	// Consumer in decode
	input  reg_idx_t id_rs1,
	input  reg_idx_t id_rs2,
	input  logic     id_reg2used,
	input  opcode_t  id_opcode,

	// Producer in execute
	input  reg_idx_t ex_rd,
	input  logic     ex_rd_en,
	input  opcode_t  ex_opcode,

	// Producer in memory
	input  reg_idx_t mem_rd,
	input  logic     mem_rd_en,

	input  logic     mem_stall,
	input  logic     dbg_stall,

	output logic     stall_id,
	output logic     stall_all,
	output logic     fwd_mem_a,
	output logic     fwd_mem_b,
	output logic     fwd_wb_a,
	output logic     fwd_wb_b
);

	logic ex_hit_a;
	logic ex_hit_b;
	logic mem_hit_a;
	logic mem_hit_b;

	logic id_store;
	logic id_jump;
	logic ex_load;

	logic load_use;
	logic ex_no_fwd;
	logic mem_no_fwd;

	// Source matches against the execute destination
	// rs2 only counts when the instruction actually reads it
	assign ex_hit_a = ex_rd_en && (id_rs1 == ex_rd);
	assign ex_hit_b = ex_rd_en && id_reg2used && (id_rs2 == ex_rd);

	// Source matches against the memory destination
	assign mem_hit_a = mem_rd_en && (id_rs1 == mem_rd);
	assign mem_hit_b = mem_rd_en && id_reg2used && (id_rs2 == mem_rd);

	assign id_store = is_store(id_opcode);
	assign id_jump  = is_jump(id_opcode);
	assign ex_load  = is_load(ex_opcode);

	// Load data is not ready until the memory stage
	assign load_use = ex_load && (ex_hit_a || ex_hit_b);

	// Jump target and store data are consumed before forwarding can reach them,
	// so they wait until the producer is in writeback and the register file
	// supplies the value
	assign ex_no_fwd  = (id_jump && ex_hit_a) || (id_store && ex_hit_b);
	assign mem_no_fwd = (id_jump && mem_hit_a) || (id_store && mem_hit_b);

	assign stall_all = mem_stall | dbg_stall;
	assign stall_id  = stall_all | load_use | ex_no_fwd | mem_no_fwd;

	// Selects take effect one cycle later, when the consumer reaches execute
	// and the producers have each moved one stage on
	always_ff @(posedge clk) begin
		if (reset) begin
			fwd_mem_a <= 1'b0;
			fwd_mem_b <= 1'b0;
			fwd_wb_a  <= 1'b0;
			fwd_wb_b  <= 1'b0;
		end else if (!stall_all) begin
			fwd_mem_a <= ex_hit_a && !ex_load;
			fwd_mem_b <= ex_hit_b && !ex_load;
			fwd_wb_a  <= mem_hit_a;
			fwd_wb_b  <= mem_hit_b;
		end
	end

endmodule

`default_nettype wire

/* logic/core_top.sv */
`default_nettype none
`timescale 1ns/1ns

module core_top
	import core_pkg::*;
#(
	parameter int DATA_W = WORD_W
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     issue,
	input  instr_t   instr,
	input  logic     mem_stall,
	input  logic     dbg_stall,
	output logic     stall_id,
	output logic     wb_valid,
	output logic     wb_we,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	logic    dec_valid;
	instr_t  dec_instr;
	id_ex_t  ex_d;
	id_ex_t  ex_q;
	ex_mem_t mem_d;
	ex_mem_t mem_q;
	mem_wb_t wb_d;
	mem_wb_t wb_q;

	logic  stall_all;
	logic  ex_rd_en;
	logic  mem_rd_en;
	logic  fwd_mem_a;
	logic  fwd_mem_b;
	logic  fwd_wb_a;
	logic  fwd_wb_b;
	word_t rd1;
	word_t rd2;
	word_t op_a;
	word_t op_b;
	word_t ex_result;
	word_t ex_addr;
	word_t load_result;

	// Decode holds under any stall; the source keeps its instruction meanwhile
	stage_reg #(.payload_t(logic)) u_dec_valid (
		.clk    (clk),
		.reset  (reset),
		.hold   (stall_id),
		.bubble (1'b0),
		.d      (issue),
		.q      (dec_valid)
	);

	stage_reg #(.payload_t(instr_t)) u_dec_reg (
		.clk    (clk),
		.reset  (reset),
		.hold   (stall_id),
		.bubble (1'b0),
		.d      (instr),
		.q      (dec_instr)
	);

	reg_file #(.DATA_W(DATA_W)) u_reg_file (
		.clk    (clk),
		.reset  (reset),
		.rs1    (dec_instr.rs1),
		.rs2    (dec_instr.rs2),
		.we     (wb_we),
		.wd_idx (wb_q.rd),
		.wdata  (wb_q.result),
		.rd1    (rd1),
		.rd2    (rd2)
	);

	// An empty decode slot or a bubble downstream never matches
	assign ex_rd_en  = dec_valid & ex_q.valid & ex_q.rd_en;
	assign mem_rd_en = dec_valid & mem_q.valid & mem_q.rd_en;

	hazard_detect u_hazard (
		.clk         (clk),
		.reset       (reset),
		.id_rs1      (dec_instr.rs1),
		.id_rs2      (dec_instr.rs2),
		.id_reg2used (dec_instr.reg2used),
		.id_opcode   (dec_instr.opcode),
		.ex_rd       (ex_q.rd),
		.ex_rd_en    (ex_rd_en),
		.ex_opcode   (ex_q.opcode),
		.mem_rd      (mem_q.rd),
		.mem_rd_en   (mem_rd_en),
		.mem_stall   (mem_stall),
		.dbg_stall   (dbg_stall),
		.stall_id    (stall_id),
		.stall_all   (stall_all),
		.fwd_mem_a   (fwd_mem_a),
		.fwd_mem_b   (fwd_mem_b),
		.fwd_wb_a    (fwd_wb_a),
		.fwd_wb_b    (fwd_wb_b)
	);

	assign ex_d = '{
		valid:    dec_valid,
		opcode:   dec_instr.opcode,
		rd:       dec_instr.rd,
		rd_en:    dec_instr.rd_en,
		reg2used: dec_instr.reg2used,
		imm:      dec_instr.imm,
		rs1_val:  rd1,
		rs2_val:  rd2
	};

	// A decode-only stall sends a bubble into execute
	stage_reg #(.payload_t(id_ex_t)) u_ex_reg (
		.clk    (clk),
		.reset  (reset),
		.hold   (stall_all),
		.bubble (stall_id),
		.d      (ex_d),
		.q      (ex_q)
	);

	operand_forward #(.DATA_W(DATA_W)) u_fwd (
		.id_a       (ex_q.rs1_val),
		.id_b       (ex_q.rs2_val),
		.mem_result (mem_q.result),
		.wb_result  (wb_q.result),
		.fwd_mem_a  (fwd_mem_a),
		.fwd_mem_b  (fwd_mem_b),
		.fwd_wb_a   (fwd_wb_a),
		.fwd_wb_b   (fwd_wb_b),
		.op_a       (op_a),
		.op_b       (op_b)
	);

	exec_unit #(.DATA_W(DATA_W)) u_exec (
		.op_a        (op_a),
		.op_b        (op_b),
		.imm         (ex_q.imm),
		.reg2used    (ex_q.reg2used),
		.mem_opcode  (mem_q.opcode),
		.mem_result  (mem_q.result),
		.mem_addr    (mem_q.addr),
		.ex_result   (ex_result),
		.ex_addr     (ex_addr),
		.load_result (load_result)
	);

	assign mem_d = '{
		valid:  ex_q.valid,
		opcode: ex_q.opcode,
		rd:     ex_q.rd,
		rd_en:  ex_q.rd_en,
		result: ex_result,
		addr:   ex_addr
	};

	stage_reg #(.payload_t(ex_mem_t)) u_mem_reg (
		.clk    (clk),
		.reset  (reset),
		.hold   (stall_all),
		.bubble (1'b0),
		.d      (mem_d),
		.q      (mem_q)
	);

	assign wb_d = '{
		valid:  mem_q.valid,
		rd:     mem_q.rd,
		rd_en:  mem_q.rd_en,
		result: load_result
	};

	stage_reg #(.payload_t(mem_wb_t)) u_wb_reg (
		.clk    (clk),
		.reset  (reset),
		.hold   (stall_all),
		.bubble (1'b0),
		.d      (wb_d),
		.q      (wb_q)
	);

	// Retirement port
	assign wb_valid = wb_q.valid;
	assign wb_we    = wb_q.valid & wb_q.rd_en;
	assign wb_rd    = wb_q.rd;
	assign wb_data  = wb_q.result;

endmodule

`default_nettype wire

/* bench/tb_core.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_core
	import core_pkg::*;
	import isa_pkg::*;
();

	localparam int RESET_CYCLES   = 10;
	localparam int N_DIRECTED     = 17;
	localparam int N_RANDOM       = 80;
	localparam int N_STALLED      = 60;
	localparam int TIMEOUT_CYCLES = 20 * (N_DIRECTED + N_RANDOM + N_STALLED) + RESET_CYCLES;

	// Plain arithmetic opcode outside the load, store and jump classes
	localparam opcode_t OP_ALU = 6'h01;

	localparam int CLS_ALU   = 0;
	localparam int CLS_LOAD  = 1;
	localparam int CLS_STORE = 2;
	localparam int CLS_JUMP  = 3;

	// Producer as seen by the hazard rules
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     rd_en;
		logic     load;
	} slot_t;

	typedef struct packed {
		reg_idx_t rd;
		logic     rd_en;
		word_t    data;
	} retire_t;

	logic     clk;
	logic     reset;
	logic     issue;
	instr_t   instr;
	logic     mem_stall;
	logic     dbg_stall;
	logic     stall_id;
	logic     wb_valid;
	logic     wb_we;
	reg_idx_t wb_rd;
	word_t    wb_data;

	// Architectural registers and pipeline occupancy of the reference model
	word_t   arch [32];
	instr_t  prog_q [$];
	retire_t exp_q [$];
	logic    dec_valid_m;
	instr_t  dec_m;
	slot_t   ex_m;
	slot_t   mem_m;
	logic    wb_valid_m;

	logic       presenting;
	logic       last_frozen;
	word_t      prev_wb_data;
	logic       use_gaps;
	logic [1:0] stall_mode;
	int         seed;
	int         data_errs;
	int         stall_errs;
	int         prop_errs;
	int         retired;
	int         cycle_count;

	core_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.instr     (instr),
		.mem_stall (mem_stall),
		.dbg_stall (dbg_stall),
		.stall_id  (stall_id),
		.wb_valid  (wb_valid),
		.wb_we     (wb_we),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// An external freeze must always show up on stall_id
	stall_input_check: assert property (@(posedge clk) disable iff (reset)
		(mem_stall || dbg_stall) |-> stall_id)
	else begin
		prop_errs++;
		$display("Fail stall_id: got %h expected %h", 1'b0, 1'b1);
	end

	// On the first edge out of reset nothing retires and only the stall inputs drive stall_id
	reset_state_check: assert property (@(posedge clk)
		$fell(reset) |-> (!wb_valid && (stall_id == (mem_stall || dbg_stall))))
	else begin
		prop_errs++;
		$display("pipeline not idle on the first cycle after reset");
	end

	function automatic int classify_op(input opcode_t op);
		case (op)
			OP_LD, OP_LD2:         return CLS_LOAD;
			OP_ST, OP_ST2, OP_ST3: return CLS_STORE;
			OP_JMP, OP_JMP2:       return CLS_JUMP;
			default:               return CLS_ALU;
		endcase
	endfunction

	// Stall expected for the instruction now in decode
	function automatic logic predict_stall();
		logic ex_a;
		logic ex_b;
		logic mem_a;
		logic mem_b;
		int   cls;
		if (mem_stall || dbg_stall)
			return 1'b1;
		if (!dec_valid_m)
			return 1'b0;
		cls   = classify_op(dec_m.opcode);
		ex_a  = ex_m.valid && ex_m.rd_en && (dec_m.rs1 == ex_m.rd);
		ex_b  = ex_m.valid && ex_m.rd_en && dec_m.reg2used && (dec_m.rs2 == ex_m.rd);
		mem_a = mem_m.valid && mem_m.rd_en && (dec_m.rs1 == mem_m.rd);
		mem_b = mem_m.valid && mem_m.rd_en && dec_m.reg2used && (dec_m.rs2 == mem_m.rd);
		if (ex_m.load && (ex_a || ex_b))
			return 1'b1;
		if ((cls == CLS_JUMP) && (ex_a || mem_a))
			return 1'b1;
		if ((cls == CLS_STORE) && (ex_b || mem_b))
			return 1'b1;
		return 1'b0;
	endfunction

	task automatic push_instr(input opcode_t op, input reg_idx_t rd, input logic rd_en,
			input reg_idx_t rs1, input reg_idx_t rs2, input logic reg2used, input word_t imm);
		prog_q.push_back('{opcode: op, rs1: rs1, rs2: rs2, rd: rd, rd_en: rd_en,
			reg2used: reg2used, imm: imm});
	endtask

	// Small register range keeps dependencies frequent
	task automatic add_random(input int count);
		instr_t ins;
		for (int i = 0; i < count; i++) begin
			case ($unsigned($random(seed)) % 10)
				0:       ins.opcode = OP_LD;
				1:       ins.opcode = OP_LD2;
				2:       ins.opcode = OP_ST;
				3:       ins.opcode = OP_ST2;
				4:       ins.opcode = OP_ST3;
				5:       ins.opcode = OP_JMP;
				6:       ins.opcode = OP_JMP2;
				default: ins.opcode = OP_ALU;
			endcase
			ins.rs1      = reg_idx_t'($unsigned($random(seed)) % 8);
			ins.rs2      = reg_idx_t'($unsigned($random(seed)) % 8);
			ins.rd       = reg_idx_t'($unsigned($random(seed)) % 8);
			ins.rd_en    = ($unsigned($random(seed)) % 4) != 0;
			ins.reg2used = 1'($unsigned($random(seed)) % 2);
			ins.imm      = $random(seed);
			prog_q.push_back(ins);
		end
	endtask

	// Architectural result of one accepted instruction
	task automatic model_accept(input instr_t ins);
		word_t a;
		word_t b;
		word_t data;
		a = arch[ins.rs1];
		b = ins.reg2used ? arch[ins.rs2] : ins.imm;
		if (classify_op(ins.opcode) == CLS_LOAD)
			data = (a + ins.imm) ^ LOAD_SALT;
		else
			data = a + b;
		if (ins.rd_en)
			arch[ins.rd] = data;
		exp_q.push_back('{rd: ins.rd, rd_en: ins.rd_en, data: data});
	endtask

	task automatic check_retire();
		retire_t exp;
		assert (wb_valid === wb_valid_m) else begin
			data_errs++;
			$display("Fail wb_valid: got %h expected %h", wb_valid, wb_valid_m);
		end
		if (last_frozen) begin
			assert (wb_data === prev_wb_data) else begin
				data_errs++;
				$display("Fail wb_data: got %h expected %h while frozen",
					wb_data, prev_wb_data);
			end
		end else if (wb_valid) begin
			if (exp_q.size() == 0) begin
				data_errs++;
				$display("retirement seen with no instruction outstanding");
			end else begin
				exp = exp_q.pop_front();
				retired++;
				assert (wb_rd === exp.rd) else begin
					data_errs++;
					$display("Fail wb_rd: got %h expected %h", wb_rd, exp.rd);
				end
				assert (wb_we === exp.rd_en) else begin
					data_errs++;
					$display("Fail wb_we: got %h expected %h", wb_we, exp.rd_en);
				end
				assert (wb_data === exp.data) else begin
					data_errs++;
					$display("Fail wb_data: got %h expected %h", wb_data, exp.data);
				end
			end
		end
		prev_wb_data = wb_data;
	endtask

	// Model occupancy moves as the coming edge will move it
	task automatic advance_model(input logic stall);
		wb_valid_m = mem_m.valid;
		mem_m      = ex_m;
		if (stall) begin
			ex_m = '0;
		end else begin
			ex_m.valid  = dec_valid_m;
			ex_m.rd     = dec_m.rd;
			ex_m.rd_en  = dec_m.rd_en;
			ex_m.load   = classify_op(dec_m.opcode) == CLS_LOAD;
			dec_valid_m = issue;
			dec_m       = instr;
			if (issue) begin
				model_accept(instr);
				presenting = 1'b0;
			end
		end
	endtask

	task automatic step_cycle();
		logic gap;
		logic pred;
		logic frozen;
		@(negedge clk);
		gap = use_gaps && (($unsigned($random(seed)) % 5) == 0);
		// The source holds its instruction until decode takes it
		if (!presenting) begin
			if ((prog_q.size() > 0) && !gap) begin
				instr      = prog_q.pop_front();
				issue      = 1'b1;
				presenting = 1'b1;
			end else begin
				issue = 1'b0;
			end
		end
		mem_stall = stall_mode[0] && (($unsigned($random(seed)) % 6) == 0);
		dbg_stall = stall_mode[1] && (($unsigned($random(seed)) % 7) == 0);
		#1;
		check_retire();
		pred = predict_stall();
		assert (stall_id === pred) else begin
			stall_errs++;
			$display("Fail stall_id: got %h expected %h", stall_id, pred);
		end
		frozen = mem_stall || dbg_stall;
		if (!frozen)
			advance_model(pred);
		last_frozen = frozen;
	endtask

	task automatic run_program();
		while ((prog_q.size() > 0) || presenting || (exp_q.size() > 0))
			step_cycle();
	endtask

	task automatic print_report(input logic timed_out);
		int total;
		total = data_errs + stall_errs + prop_errs;
		$display("errors: data %0d, stall %0d, property %0d, total %0d, retired %0d",
			data_errs, stall_errs, prop_errs, total, retired);
		if ((total == 0) && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_report(1'b1);
		end
	end

	initial begin
		seed          = 32'h6a16_f569;
		reset         = 1'b1;
		issue         = 1'b0;
		instr         = '0;
		mem_stall     = 1'b0;
		dbg_stall     = 1'b0;
		dec_valid_m   = 1'b0;
		dec_m         = '0;
		ex_m          = '0;
		mem_m         = '0;
		wb_valid_m    = 1'b0;
		presenting    = 1'b0;
		last_frozen   = 1'b0;
		prev_wb_data  = '0;
		use_gaps      = 1'b0;
		stall_mode    = 2'b00;
		data_errs     = 0;
		stall_errs    = 0;
		prop_errs     = 0;
		retired       = 0;
		cycle_count   = 0;
		for (int i = 0; i < 32; i++)
			arch[i] = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Idle pipeline after reset
		repeat (6) step_cycle();

		// Arithmetic chain through the memory and writeback forwarding paths
		push_instr(OP_ALU, 5'd1, 1'b1, 5'd0, 5'd0, 1'b0, 32'h10);
		push_instr(OP_ALU, 5'd2, 1'b1, 5'd1, 5'd0, 1'b0, 32'h22);
		push_instr(OP_ALU, 5'd3, 1'b1, 5'd1, 5'd2, 1'b1, 32'h0);
		push_instr(OP_ALU, 5'd1, 1'b1, 5'd3, 5'd2, 1'b1, 32'h0);
		push_instr(OP_ALU, 5'd4, 1'b1, 5'd1, 5'd3, 1'b1, 32'h0);
		// Load followed by users, one with rs2 unused
		push_instr(OP_LD, 5'd5, 1'b1, 5'd4, 5'd0, 1'b0, 32'h100);
		push_instr(OP_ALU, 5'd6, 1'b1, 5'd5, 5'd1, 1'b1, 32'h0);
		push_instr(OP_LD2, 5'd2, 1'b1, 5'd6, 5'd0, 1'b0, 32'h40);
		push_instr(OP_ALU, 5'd7, 1'b1, 5'd3, 5'd2, 1'b0, 32'h9);
		push_instr(OP_ALU, 5'd0, 1'b1, 5'd7, 5'd2, 1'b1, 32'h0);
		// Store and jump consumers of fresh results
		push_instr(OP_ALU, 5'd1, 1'b1, 5'd5, 5'd0, 1'b0, 32'h7);
		push_instr(OP_ST, 5'd0, 1'b0, 5'd3, 5'd1, 1'b1, 32'h20);
		push_instr(OP_ALU, 5'd2, 1'b1, 5'd0, 5'd0, 1'b0, 32'h3);
		push_instr(OP_ALU, 5'd3, 1'b1, 5'd6, 5'd4, 1'b1, 32'h0);
		push_instr(OP_JMP, 5'd7, 1'b1, 5'd2, 5'd0, 1'b0, 32'h4);
		push_instr(OP_JMP2, 5'd6, 1'b1, 5'd3, 5'd0, 1'b0, 32'h8);
		push_instr(OP_ST3, 5'd0, 1'b0, 5'd1, 5'd7, 1'b1, 32'h0);
		run_program();

		// Random stream with issue gaps
		use_gaps = 1'b1;
		add_random(N_RANDOM);
		run_program();

		// Random stream under memory and debug freezes
		stall_mode = 2'b11;
		add_random(N_STALLED);
		run_program();

		print_report(1'b0);
	end

endmodule

`default_nettype wire

/* src.f */
logic/isa_pkg.sv
logic/core_pkg.sv
logic/stage_reg.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/exec_unit.sv
logic/hazard_detect.sv
logic/core_top.sv
bench/tb_core.sv

/* Bender.yml */
package:
  name: core_pipeline

sources:
  - logic/isa_pkg.sv
  - logic/core_pkg.sv
  - logic/stage_reg.sv
  - logic/reg_file.sv
  - logic/operand_forward.sv
  - logic/exec_unit.sv
  - logic/hazard_detect.sv
  - logic/core_top.sv
  - target: test
    files:
      - bench/tb_core.sv
